// ==== all.f ====
+incdir+include
design/osd_pkg.sv
design/video_timing_gen.sv
design/osd_window.sv
design/osd_pixel_fetch.sv
design/osd_buffer_arbiter.sv
design/osd_buffer_ram.sv
design/osd_overlay_top.sv
verification/tb_osd_overlay.sv

// ==== design/osd_buffer_arbiter.sv ====
// Overlay buffer arbiter giving fetch reads priority over a one-entry pending host write.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module osd_buffer_arbiter
(
  input  wire                        clk_pixel,
  input  wire                        i_rst_n,
  input  wire                        i_fetch_req,
  input  wire  [`OSD_BUF_ADDR_W-1:0] i_fetch_addr,
  input  wire                        i_host_we,
  input  wire  [`OSD_BUF_ADDR_W-1:0] i_host_addr,
  input  wire  [7:0]                 i_host_data,
  output logic [7:0]                 o_fetch_data,
  output logic                       o_host_busy,
  output logic                       o_ram_en,
  output logic                       o_ram_we,
  output logic [`OSD_BUF_ADDR_W-1:0] o_ram_addr,
  output logic [7:0]                 o_ram_wdata,
  input  wire  [7:0]                 i_ram_rdata
);

  import osd_pkg::*;

  arb_grant_e                 grant;
  arb_grant_e                 grant_q;
  logic                       pend_valid;
  logic [`OSD_BUF_ADDR_W-1:0] pend_addr;
  logic [7:0]                 pend_data;

  always_comb
  begin
    if (i_fetch_req)
      grant = GRANT_FETCH;
    else if (pend_valid)
      grant = GRANT_HOST;
    else
      grant = GRANT_IDLE;
  end

  assign o_ram_en    = (grant != GRANT_IDLE);
  assign o_ram_we    = (grant == GRANT_HOST);
  assign o_ram_addr  = (grant == GRANT_FETCH) ? i_fetch_addr : pend_addr;
  assign o_ram_wdata = pend_data;
  assign o_host_busy = pend_valid;

  // Read data belongs to whoever held the port one clock earlier.
  assign o_fetch_data = (grant_q == GRANT_FETCH) ? i_ram_rdata : 8'h00;

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      grant_q    <= GRANT_IDLE;
      pend_valid <= 1'b0;
    end
    else
    begin
      grant_q <= grant;
      if (i_host_we)
        pend_valid <= 1'b1;
      else if (grant == GRANT_HOST)
        pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_host_we)
    begin
      pend_addr <= i_host_addr;
      pend_data <= i_host_data;
    end
  end

  a_host_respects_busy: assert property (@(posedge clk_pixel) disable iff (!i_rst_n)
    i_host_we |-> !o_host_busy);

  a_fetch_read_only: assert property (@(posedge clk_pixel) disable iff (!i_rst_n)
    i_fetch_req |-> (o_ram_en && !o_ram_we && (o_ram_addr == i_fetch_addr)));

endmodule

`default_nettype wire

// ==== design/osd_buffer_ram.sv ====
// Single-port overlay buffer memory of RGB332 entries with a registered read.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module osd_buffer_ram
(
  input  wire                       clk_pixel,
  input  wire                       i_en,
  input  wire                       i_we,
  input  wire [`OSD_BUF_ADDR_W-1:0] i_addr,
  input  wire [7:0]                 i_wdata,
  output logic [7:0]                o_rdata
);

  logic [7:0] mem [0:`OSD_BUF_DEPTH-1];

  // Unwritten entries show as black.
  initial
  begin
    for (int i = 0; i < `OSD_BUF_DEPTH; i++)
      mem[i] = 8'h00;
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_en)
    begin
      if (i_we)
        mem[i_addr] <= i_wdata;
      else
        o_rdata <= mem[i_addr];
    end
  end

endmodule

`default_nettype wire

// ==== design/osd_overlay_top.sv ====
// OSD overlay top level joining timing generator, window, fetch, arbiter and buffer.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module osd_overlay_top
(
  input  wire                       clk_pixel,
  input  wire                       i_rst_n,
  input  wire                       i_pixel_ena,
  input  wire                       i_host_we,
  input  wire [`OSD_BUF_ADDR_W-1:0] i_host_addr,
  input  wire [7:0]                 i_host_data,
  output logic [7:0]                o_r,
  output logic [7:0]                o_g,
  output logic [7:0]                o_b,
  output logic                      o_hsync,
  output logic                      o_vsync,
  output logic                      o_blank,
  output logic                      o_host_busy
);

  import osd_pkg::*;

  logic [7:0]                 vid_r, vid_g, vid_b;
  logic                       vid_hsync, vid_vsync, vid_blank;
  coord_t                     osd_x, osd_y;
  logic                       osd_active;
  logic                       fetch_req;
  logic [`OSD_BUF_ADDR_W-1:0] fetch_addr;
  logic [7:0]                 fetch_data;
  logic [7:0]                 osd_r, osd_g, osd_b;
  logic                       ram_en, ram_we;
  logic [`OSD_BUF_ADDR_W-1:0] ram_addr;
  logic [7:0]                 ram_wdata, ram_rdata;

  video_timing_gen u_timing (
    .clk_pixel(clk_pixel), .i_rst_n(i_rst_n), .i_pixel_ena(i_pixel_ena),
    .o_r(vid_r), .o_g(vid_g), .o_b(vid_b),
    .o_hsync(vid_hsync), .o_vsync(vid_vsync), .o_blank(vid_blank)
  );

  osd_window u_window (
    .clk_pixel(clk_pixel), .i_rst_n(i_rst_n), .i_pixel_ena(i_pixel_ena),
    .i_r(vid_r), .i_g(vid_g), .i_b(vid_b),
    .i_hsync(vid_hsync), .i_vsync(vid_vsync), .i_blank(vid_blank),
    .i_osd_r(osd_r), .i_osd_g(osd_g), .i_osd_b(osd_b),
    .o_osd_x(osd_x), .o_osd_y(osd_y), .o_osd_active(osd_active),
    .o_r(o_r), .o_g(o_g), .o_b(o_b),
    .o_hsync(o_hsync), .o_vsync(o_vsync), .o_blank(o_blank)
  );

  osd_pixel_fetch u_fetch (
    .clk_pixel(clk_pixel), .i_rst_n(i_rst_n), .i_pixel_ena(i_pixel_ena),
    .i_osd_x(osd_x), .i_osd_y(osd_y), .i_osd_active(osd_active),
    .o_fetch_req(fetch_req), .o_fetch_addr(fetch_addr), .i_fetch_data(fetch_data),
    .o_osd_r(osd_r), .o_osd_g(osd_g), .o_osd_b(osd_b)
  );

  osd_buffer_arbiter u_arbiter (
    .clk_pixel(clk_pixel), .i_rst_n(i_rst_n),
    .i_fetch_req(fetch_req), .i_fetch_addr(fetch_addr),
    .i_host_we(i_host_we), .i_host_addr(i_host_addr), .i_host_data(i_host_data),
    .o_fetch_data(fetch_data), .o_host_busy(o_host_busy),
    .o_ram_en(ram_en), .o_ram_we(ram_we), .o_ram_addr(ram_addr),
    .o_ram_wdata(ram_wdata), .i_ram_rdata(ram_rdata)
  );

  osd_buffer_ram u_ram (
    .clk_pixel(clk_pixel), .i_en(ram_en), .i_we(ram_we),
    .i_addr(ram_addr), .i_wdata(ram_wdata), .o_rdata(ram_rdata)
  );

endmodule

`default_nettype wire

// ==== design/osd_pixel_fetch.sv ====
// OSD pixel fetch that maps window coordinates to buffer reads and expands RGB332 colour.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module osd_pixel_fetch
(
  input  wire                        clk_pixel,
  input  wire                        i_rst_n,
  input  wire                        i_pixel_ena,
  input  wire osd_pkg::coord_t       i_osd_x,
  input  wire osd_pkg::coord_t       i_osd_y,
  input  wire                        i_osd_active,
  output logic                       o_fetch_req,
  output logic [`OSD_BUF_ADDR_W-1:0] o_fetch_addr,
  input  wire  [7:0]                 i_fetch_data,
  output logic [7:0]                 o_osd_r,
  output logic [7:0]                 o_osd_g,
  output logic [7:0]                 o_osd_b
);

  logic [9:0] blk_x;
  logic [9:0] blk_y;
  logic [9:0] blk_index;

  // One buffer entry covers a square block of window pixels.
  assign blk_x     = i_osd_x >> `OSD_BLOCK_SHIFT;
  assign blk_y     = i_osd_y >> `OSD_BLOCK_SHIFT;
  assign blk_index = blk_y * 10'(`OSD_BUF_COLS) + blk_x;

  assign o_fetch_req  = i_pixel_ena && i_osd_active;
  assign o_fetch_addr = blk_index[`OSD_BUF_ADDR_W-1:0];

  // RGB332 to RGB888 by repeating the top bits of each field.
  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      o_osd_r <= 8'h00;
      o_osd_g <= 8'h00;
      o_osd_b <= 8'h00;
    end
    else if (i_pixel_ena)
    begin
      o_osd_r <= {i_fetch_data[7:5], i_fetch_data[7:5], i_fetch_data[7:6]};
      o_osd_g <= {i_fetch_data[4:2], i_fetch_data[4:2], i_fetch_data[4:3]};
      o_osd_b <= {4{i_fetch_data[1:0]}};
    end
  end

endmodule

`default_nettype wire

// ==== design/osd_pkg.sv ====
// Shared types for the OSD overlay: arbiter grant, horizontal phase and coordinates.
`default_nettype none

package osd_pkg;

  // Owner of the buffer port in a given clock.
  typedef enum logic [1:0]
  {
    GRANT_IDLE  = 2'd0,
    GRANT_FETCH = 2'd1,
    GRANT_HOST  = 2'd2
  } arb_grant_e;

  // Horizontal line phases, in scan order.
  typedef enum logic [1:0]
  {
    H_ACTIVE = 2'd0,
    H_FRONT  = 2'd1,
    H_SYNC   = 2'd2,
    H_BACK   = 2'd3
  } h_phase_e;

  typedef logic [9:0] coord_t;

endpackage

`default_nettype wire

// ==== design/osd_window.sv ====
// OSD window detector that tracks screen position and overlays buffer pixels in the window.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module osd_window
(
  input  wire                   clk_pixel,
  input  wire                   i_rst_n,
  input  wire                   i_pixel_ena,
  input  wire  [7:0]            i_r,
  input  wire  [7:0]            i_g,
  input  wire  [7:0]            i_b,
  input  wire                   i_hsync,
  input  wire                   i_vsync,
  input  wire                   i_blank,
  input  wire  [7:0]            i_osd_r,
  input  wire  [7:0]            i_osd_g,
  input  wire  [7:0]            i_osd_b,
  output osd_pkg::coord_t       o_osd_x,
  output osd_pkg::coord_t       o_osd_y,
  output logic                  o_osd_active,
  output logic [7:0]            o_r,
  output logic [7:0]            o_g,
  output logic [7:0]            o_b,
  output logic                  o_hsync,
  output logic                  o_vsync,
  output logic                  o_blank
);

  import osd_pkg::*;

  localparam coord_t X_PRE  = coord_t'(`OSD_X_START - 1);
  localparam coord_t X_STOP = coord_t'(`OSD_X_STOP);
  localparam coord_t Y_PRE  = coord_t'(`OSD_Y_START - 1);
  localparam coord_t Y_STOP = coord_t'(`OSD_Y_STOP);
  localparam coord_t W_LAST = coord_t'(`OSD_X_STOP - `OSD_X_START);

  logic       hsync_prev;
  logic       hsync_rise;
  logic       ycount_en;
  coord_t     x_cnt;
  coord_t     y_cnt;
  logic       x_flag;
  logic       y_flag;
  logic [7:0] r_d1, g_d1, b_d1;
  logic [7:0] r_d2, g_d2, b_d2;
  logic       hs_d1, vs_d1, bl_d1, act_d1;
  logic       hs_d2, vs_d2, bl_d2, act_d2;

  assign hsync_rise = i_hsync && !hsync_prev;

  // The counters and flags describe the pixel currently at the input.
  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      hsync_prev <= 1'b0;
      ycount_en  <= 1'b0;
      x_cnt      <= '0;
      y_cnt      <= '0;
      x_flag     <= 1'b0;
      y_flag     <= 1'b0;
      o_osd_x    <= '0;
      o_osd_y    <= '0;
    end
    else if (i_pixel_ena)
    begin
      hsync_prev <= i_hsync;
      if (hsync_rise)
      begin
        x_cnt  <= '0;
        x_flag <= 1'b0;
      end
      else if (!i_blank)
      begin
        x_cnt <= x_cnt + 10'd1;
        if (x_cnt == X_PRE)
        begin
          x_flag  <= 1'b1;
          o_osd_x <= '0;
        end
        else if (x_cnt == X_STOP)
          x_flag <= 1'b0;
        else if (x_flag)
          o_osd_x <= o_osd_x + 10'd1;
      end
      if (i_vsync)
      begin
        y_cnt     <= '0;
        ycount_en <= 1'b0;
        y_flag    <= 1'b0;
      end
      else
      begin
        // Lines count only once the frame has shown its first pixel.
        if (!i_blank)
          ycount_en <= 1'b1;
        if (hsync_rise && ycount_en)
        begin
          y_cnt <= y_cnt + 10'd1;
          if (y_cnt == Y_PRE)
          begin
            y_flag  <= 1'b1;
            o_osd_y <= '0;
          end
          else if (y_cnt == Y_STOP)
            y_flag <= 1'b0;
          else if (y_flag)
            o_osd_y <= o_osd_y + 10'd1;
        end
      end
    end
  end

  assign o_osd_active = x_flag && y_flag;

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      {hs_d1, vs_d1, bl_d1, act_d1} <= 4'b0010;
      {hs_d2, vs_d2, bl_d2, act_d2} <= 4'b0010;
    end
    else if (i_pixel_ena)
    begin
      {hs_d1, vs_d1, bl_d1, act_d1} <= {i_hsync, i_vsync, i_blank, o_osd_active};
      {hs_d2, vs_d2, bl_d2, act_d2} <= {hs_d1, vs_d1, bl_d1, act_d1};
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_pixel_ena)
    begin
      {r_d1, g_d1, b_d1} <= {i_r, i_g, i_b};
      {r_d2, g_d2, b_d2} <= {r_d1, g_d1, b_d1};
    end
  end

  // Fetched overlay colour lines up with the second stage.
  assign o_r     = act_d2 ? i_osd_r : r_d2;
  assign o_g     = act_d2 ? i_osd_g : g_d2;
  assign o_b     = act_d2 ? i_osd_b : b_d2;
  assign o_hsync = hs_d2;
  assign o_vsync = vs_d2;
  assign o_blank = bl_d2;

  a_osd_x_range: assert property (@(posedge clk_pixel) disable iff (!i_rst_n)
    o_osd_active |-> (o_osd_x <= W_LAST));

endmodule

`default_nettype wire

// ==== design/video_timing_gen.sv ====
// Video timing generator producing syncs, blank and an x/y test-pattern background.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module video_timing_gen
(
  input  wire        clk_pixel,
  input  wire        i_rst_n,
  input  wire        i_pixel_ena,
  output logic [7:0] o_r,
  output logic [7:0] o_g,
  output logic [7:0] o_b,
  output logic       o_hsync,
  output logic       o_vsync,
  output logic       o_blank
);

  import osd_pkg::*;

  localparam coord_t H_ACT_LAST   = coord_t'(`OSD_H_ACTIVE - 1);
  localparam coord_t H_FRONT_LAST = coord_t'(`OSD_H_ACTIVE + `OSD_H_FRONT - 1);
  localparam coord_t H_SYNC_LAST  = coord_t'(`OSD_H_ACTIVE + `OSD_H_FRONT + `OSD_H_SYNC - 1);
  localparam coord_t H_LAST       = coord_t'(`OSD_H_TOTAL - 1);
  localparam coord_t V_ACT        = coord_t'(`OSD_V_ACTIVE);
  localparam coord_t V_SYNC_FIRST = coord_t'(`OSD_V_ACTIVE + `OSD_V_FRONT);
  localparam coord_t V_SYNC_END   = coord_t'(`OSD_V_ACTIVE + `OSD_V_FRONT + `OSD_V_SYNC);
  localparam coord_t V_LAST       = coord_t'(`OSD_V_TOTAL - 1);

  h_phase_e h_phase;
  coord_t   h_cnt;
  coord_t   v_cnt;
  coord_t   pix_xor;
  logic     pix_active;
  logic     pix_vsync;

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      h_phase <= H_ACTIVE;
      h_cnt   <= '0;
      v_cnt   <= '0;
    end
    else if (i_pixel_ena)
    begin
      h_cnt <= h_cnt + 10'd1;
      case (h_phase)
        H_ACTIVE:
          if (h_cnt == H_ACT_LAST)
            h_phase <= H_FRONT;
        H_FRONT:
          if (h_cnt == H_FRONT_LAST)
            h_phase <= H_SYNC;
        H_SYNC:
          if (h_cnt == H_SYNC_LAST)
            h_phase <= H_BACK;
        default:
          if (h_cnt == H_LAST)
          begin
            // End of line, wrap to the next one.
            h_phase <= H_ACTIVE;
            h_cnt   <= '0;
            v_cnt   <= (v_cnt == V_LAST) ? '0 : v_cnt + 10'd1;
          end
      endcase
    end
  end

  assign pix_active = (h_phase == H_ACTIVE) && (v_cnt < V_ACT);
  assign pix_vsync  = (v_cnt >= V_SYNC_FIRST) && (v_cnt < V_SYNC_END);
  assign pix_xor    = h_cnt ^ v_cnt;

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      o_hsync <= (h_phase == H_SYNC);
      o_vsync <= pix_vsync;
      o_blank <= !pix_active;
    end
  end

  // Background colour is black outside the active area.
  always_ff @(posedge clk_pixel)
  begin
    if (i_pixel_ena)
    begin
      o_r <= pix_active ? h_cnt[7:0] : 8'h00;
      o_g <= pix_active ? v_cnt[7:0] : 8'h00;
      o_b <= pix_active ? pix_xor[7:0] : 8'h00;
    end
  end

endmodule

`default_nettype wire

// ==== include/osd_defs.svh ====
// Video mode, OSD window geometry and overlay buffer shape for the overlay pipeline.
`ifndef OSD_DEFS_SVH
`define OSD_DEFS_SVH

`define OSD_H_ACTIVE    96
`define OSD_H_FRONT     8
`define OSD_H_SYNC      12
`define OSD_H_BACK      12
`define OSD_H_TOTAL     (`OSD_H_ACTIVE + `OSD_H_FRONT + `OSD_H_SYNC + `OSD_H_BACK)

`define OSD_V_ACTIVE    48
`define OSD_V_FRONT     4
`define OSD_V_SYNC      2
`define OSD_V_BACK      6
`define OSD_V_TOTAL     (`OSD_V_ACTIVE + `OSD_V_FRONT + `OSD_V_SYNC + `OSD_V_BACK)

`define OSD_X_START     16
`define OSD_X_STOP      79
`define OSD_Y_START     8
`define OSD_Y_STOP      39

`define OSD_BLOCK_SHIFT 2
`define OSD_BUF_COLS    16
`define OSD_BUF_ADDR_W  7
`define OSD_BUF_DEPTH   128

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the OSD overlay testbench with Verilator, runs it and scans the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module tb_osd_overlay -o tb_osd_overlay

./obj_dir/tb_osd_overlay | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished, see sim.log"

// ==== verification/osd_trace.txt ====
# W <addr hex> <RGB332 hex> is a host write, C <x dec> <y dec> <RGB888 hex> an expected pixel.
# Groups of writes then checks alternate: even groups written in vblank, odd ones mid-window.
W 00 e0
W 0f 1c
W 70 03
W 7f 92
C 16 8 ff0000
C 19 11 ff0000
C 79 8 00ff00
C 80 8 500858
C 16 39 0000ff
C 16 40 102838
C 15 39 0f2728
C 79 39 9292aa
C 37 17 000000
C 15 8 0f0807
W 00 6d
W 25 ff
W 40 49
C 17 9 6d6d55
C 36 16 ffffff
C 39 19 ffffff
C 18 25 494955
C 77 10 00ff00
W 00 00
W 7f b6
C 16 8 000000
C 76 36 b6b6aa
C 18 25 494955
C 80 39 502777

// ==== verification/tb_osd_overlay.sv ====
// Testbench for the OSD overlay that replays buffer writes and pixel checks from a trace.
`timescale 1ns/10ps
`default_nettype none
`include "osd_defs.svh"

module tb_osd_overlay;

  localparam int FRAME_CLOCKS = `OSD_H_TOTAL * `OSD_V_TOTAL;
  localparam int SPOT_X       = `OSD_X_START + 8;

  logic                       clk_pixel;
  logic                       i_rst_n;
  logic                       i_pixel_ena;
  logic                       i_host_we;
  logic [`OSD_BUF_ADDR_W-1:0] i_host_addr;
  logic [7:0]                 i_host_data;
  logic [7:0]                 o_r;
  logic [7:0]                 o_g;
  logic [7:0]                 o_b;
  logic                       o_hsync;
  logic                       o_vsync;
  logic                       o_blank;
  logic                       o_host_busy;

  // Trace lines, one entry per W or C line.
  bit          op_is_write[$];
  int          op_a[$];
  int          op_b[$];
  int          op_c[$];
  int          num_groups;
  logic        trace_loaded;

  logic [23:0] expected_at [int];
  int          checks_total;
  int          checks_hit;
  int          last_check_frame;

  // Screen position rebuilt from the output syncs.
  logic        hs_prev;
  logic        vs_prev;
  logic        ycount_en;
  logic        write_spot;
  int          scr_x;
  int          scr_y;
  int          line_count;
  int          frame_num;

  osd_overlay_top u_dut (
    .clk_pixel(clk_pixel), .i_rst_n(i_rst_n), .i_pixel_ena(i_pixel_ena),
    .i_host_we(i_host_we), .i_host_addr(i_host_addr), .i_host_data(i_host_data),
    .o_r(o_r), .o_g(o_g), .o_b(o_b),
    .o_hsync(o_hsync), .o_vsync(o_vsync), .o_blank(o_blank),
    .o_host_busy(o_host_busy)
  );

  initial
  begin
    clk_pixel = 1'b0;
    forever #50 clk_pixel = ~clk_pixel;
  end

  task automatic show_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
  endtask

  task automatic step_clock();
    @(posedge clk_pixel);
    #10;
  endtask

  task automatic compare_pixel(input int x, input int y, input logic [23:0] exp);
    logic [23:0] got;
    got = {o_r, o_g, o_b};
    assert (got === exp)
    else
    begin
      show_failure($sformatf("ERROR: {o_r,o_g,o_b} at x=%0d y=%0d got 0x%06h expected 0x%06h",
        x, y, got, exp));
      $fatal(1);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      show_failure($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
      $fatal(1);
    end
  endtask

  task automatic load_trace();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    string line;
    fd = $fopen("verification/osd_trace.txt", "r");
    assert (fd != 0)
    else
    begin
      show_failure("Could not open the trace file verification/osd_trace.txt.");
      $fatal(1);
    end
    num_groups = 0;
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) == "W")
      begin
        n = $sscanf(line, "W %h %h", a, b);
        assert (n == 2)
        else
        begin
          show_failure("A write line in the trace is malformed.");
          $fatal(1);
        end
        // A write after checks opens a new group.
        if (op_is_write.size() == 0 || !op_is_write[op_is_write.size() - 1])
          num_groups++;
        op_is_write.push_back(1'b1);
        op_a.push_back(a);
        op_b.push_back(b);
        op_c.push_back(0);
      end
      else if (n > 0 && line.getc(0) == "C")
      begin
        n = $sscanf(line, "C %d %d %h", a, b, c);
        assert (n == 3)
        else
        begin
          show_failure("A check line in the trace is malformed.");
          $fatal(1);
        end
        op_is_write.push_back(1'b0);
        op_a.push_back(a);
        op_b.push_back(b);
        op_c.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  task automatic host_write(input logic [`OSD_BUF_ADDR_W-1:0] addr, input logic [7:0] data,
                            input bit collide);
    int busy_clocks;
    while (o_host_busy)
      step_clock();
    i_host_we   = 1'b1;
    i_host_addr = addr;
    i_host_data = data;
    step_clock();
    i_host_we   = 1'b0;
    busy_clocks = 0;
    while (o_host_busy)
    begin
      busy_clocks++;
      step_clock();
    end
    // A free buffer takes the write on the next clock, a fetch holds it back.
    if (collide)
      assert (busy_clocks > 2)
      else
      begin
        show_failure("A host write during the window was not held back by the fetch.");
        $fatal(1);
      end
    else
      compare_count("o_host_busy clocks", busy_clocks, 1);
  endtask

  task automatic wait_write_spot();
    while (!write_spot)
      step_clock();
  endtask

  task automatic check_pixel(input int x, input int y);
    int          key;
    logic [23:0] background;
    logic        in_window;
    in_window  = (x >= `OSD_X_START) && (x <= `OSD_X_STOP) &&
                 (y >= `OSD_Y_START) && (y <= `OSD_Y_STOP);
    background = {8'(x), 8'(y), 8'(x ^ y)};
    // The buffer is still empty during the first frame.
    if (!in_window)
      compare_pixel(x, y, background);
    else if (frame_num == 0)
      compare_pixel(x, y, 24'h000000);
    key = frame_num * 65536 + y * 256 + x;
    if (expected_at.exists(key))
    begin
      compare_pixel(x, y, expected_at[key]);
      checks_hit++;
    end
  endtask

  task automatic sample_output();
    logic hs_rise;
    logic vs_rise;
    hs_rise    = o_hsync && !hs_prev;
    vs_rise    = o_vsync && !vs_prev;
    hs_prev    = o_hsync;
    vs_prev    = o_vsync;
    write_spot = 1'b0;
    if (hs_rise)
    begin
      if (scr_x != 0)
      begin
        compare_count("active pixels per line", scr_x, `OSD_H_ACTIVE);
        line_count++;
      end
      scr_x = 0;
      if (ycount_en)
        scr_y++;
    end
    else if (!o_blank)
    begin
      check_pixel(scr_x, scr_y);
      write_spot = (scr_x == SPOT_X) && (scr_y >= `OSD_Y_START) && (scr_y <= `OSD_Y_STOP);
      scr_x++;
    end
    if (vs_rise)
    begin
      compare_count("active lines per frame", line_count, `OSD_V_ACTIVE);
      line_count = 0;
      frame_num++;
    end
    if (o_vsync)
    begin
      scr_y     = 0;
      ycount_en = 1'b0;
    end
    else if (!o_blank)
      ycount_en = 1'b1;
  endtask

  always @(negedge clk_pixel)
  begin
    if (i_rst_n)
      sample_output();
  end

  initial
  begin : watchdog
    wait (trace_loaded === 1'b1);
    repeat ((2 * num_groups + 2) * FRAME_CLOCKS) @(posedge clk_pixel);
    show_failure("Timeout: the trace did not finish within the expected number of frames.");
    $fatal(1);
  end

  initial
  begin : stimulus
    int idx;
    int grp;
    int chk_frame;
    bit in_window;
    i_rst_n          = 1'b0;
    i_pixel_ena      = 1'b1;
    i_host_we        = 1'b0;
    i_host_addr      = '0;
    i_host_data      = '0;
    trace_loaded     = 1'b0;
    checks_total     = 0;
    checks_hit       = 0;
    last_check_frame = 0;
    hs_prev          = 1'b0;
    vs_prev          = 1'b0;
    ycount_en        = 1'b0;
    write_spot       = 1'b0;
    scr_x            = 0;
    scr_y            = 0;
    line_count       = 0;
    frame_num        = 0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (3) @(posedge clk_pixel);
    #10;
    i_rst_n = 1'b1;
    idx = 0;
    grp = 0;
    while (idx < op_a.size())
    begin
      // Start a group once the frames of earlier checks are over.
      while (frame_num <= last_check_frame)
        step_clock();
      in_window = (grp % 2) == 1;
      while (idx < op_a.size() && op_is_write[idx])
      begin
        if (in_window)
          wait_write_spot();
        host_write(7'(op_a[idx]), 8'(op_b[idx]), in_window);
        idx++;
      end
      // Writes made in vertical blanking show in the frame that is starting.
      chk_frame = in_window ? frame_num + 1 : frame_num;
      while (idx < op_a.size() && !op_is_write[idx])
      begin
        expected_at[chk_frame * 65536 + op_b[idx] * 256 + op_a[idx]] = 24'(op_c[idx]);
        checks_total++;
        idx++;
      end
      last_check_frame = chk_frame;
      grp++;
    end
    while (frame_num <= last_check_frame)
      step_clock();
    if (checks_hit == checks_total)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      show_failure($sformatf("ERROR: checks_hit got 0x%0h expected 0x%0h",
        checks_hit, checks_total));
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
